//--- verilog/pci_bus_pkg.sv
// PCI bus encodings
package pci_bus_pkg;

   // C/BE word decoded as a command or as byte enables
   typedef union packed {
      struct packed {
         logic [2:0] grp;
         logic       dir;
      } cmd;
      logic [3:0] be_n;
   } cbe_t;

   // Memory read 0110, memory write 0111
   localparam logic [2:0] CMD_GROUP_MEM = 3'b011;

   // Active low, so zero enables every byte lane
   localparam logic [3:0] BE_ALL = 4'b0000;

   // Status word from the core
   localparam int CSR_W = 40;

   // Either fatal bit aborts the initiator
   localparam int CSR_FATAL_HI = 39;
   localparam int CSR_FATAL_LO = 38;

   localparam int CSR_RETRY = 36;

endpackage

//--- verilog/pci_init_pkg.sv
// Initiator internal types
package pci_init_pkg;

   // Transfer states
   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      REQ     = 3'd1,
      READ    = 3'd2,
      WRITE   = 3'd3,
      DEAD    = 3'd4,
      RECOVER = 3'd5
   } init_state_t;

   // Burst length of 1 to 15 words
   localparam int LEN_W = 4;

endpackage

//--- verilog/init_sequencer.sv
// Initiator transfer sequencer
`timescale 1ns/1ns

module init_sequencer
   import pci_bus_pkg::*, pci_init_pkg::*;
(
   input  logic             CLK,
   input  logic             reset,
   input  logic             cmd_req,
   input  logic             cmd_write,
   input  logic             clear_dead,
   input  logic             m_data,
   input  logic             m_addr_n,
   input  logic             m_data_vld,
   input  logic [CSR_W-1:0] csr,
   output logic             cmd_ack,
   output logic             start,
   output logic             data_fell,
   output logic             request,
   output logic             busy,
   output logic             dead,
   output logic             m_wrdn,
   output logic             rd_valid,
   output init_state_t      state
);

   logic        m_dataq;
   logic        fatal;
   logic        dir_q;
   init_state_t next_state;

   // New command only from idle, once the previous ack has dropped
   assign start     = (state == IDLE) && cmd_req && !cmd_ack;
   assign data_fell = !m_data && m_dataq;
   assign request   = (state == REQ);
   assign busy      = (state != IDLE);
   assign dead      = (state == DEAD);
   assign m_wrdn    = dir_q;
   assign rd_valid  = (state == READ) && m_data_vld;

   always_ff @(posedge CLK or posedge reset) begin
      if (reset) begin
         m_dataq <= 1'b0;
      end else begin
         m_dataq <= m_data;
      end
   end

   // Status collected over the data phases
   always_ff @(posedge CLK or posedge reset) begin
      if (reset) begin
         fatal <= 1'b0;
      end else if (!m_addr_n) begin
         fatal <= 1'b0;
      end else if (m_data) begin
         fatal <= fatal | csr[CSR_FATAL_HI] | csr[CSR_FATAL_LO];
      end
   end

   always_ff @(posedge CLK or posedge reset) begin
      if (reset) begin
         cmd_ack <= 1'b0;
         dir_q   <= 1'b0;
      end else if (start) begin
         cmd_ack <= 1'b1;
         dir_q   <= cmd_write;
      end else if (!cmd_req) begin
         cmd_ack <= 1'b0;
      end
   end

   always_ff @(posedge CLK or posedge reset) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = IDLE;
      case (state)
         IDLE:    next_state = start ? REQ : IDLE;
         REQ:     next_state = dir_q ? WRITE : READ;
         READ, WRITE: begin
            if (data_fell) begin
               next_state = fatal ? DEAD : RECOVER;
            end else begin
               next_state = state;
            end
         end
         DEAD:    next_state = clear_dead ? IDLE : DEAD;
         RECOVER: next_state = IDLE;
         default: next_state = IDLE;
      endcase
   end

   a_request_single: assert property (@(posedge CLK) disable iff (reset)
      request |=> !request);

   a_ack_after_req: assert property (@(posedge CLK) disable iff (reset)
      $rose(cmd_ack) |-> $past(cmd_req));

endmodule

//--- verilog/burst_tracker.sv
// Burst counters and C/BE drive
`timescale 1ns/1ns

module burst_tracker
   import pci_bus_pkg::*, pci_init_pkg::*;
#(
   parameter int DATA_W = 32
) (
   input  logic              CLK,
   input  logic              reset,
   input  logic              start,
   input  logic              m_data,
   input  logic              m_data_vld,
   input  logic              m_addr_n,
   input  logic              m_wrdn,
   input  logic              request,
   input  logic              data_fell,
   input  logic [DATA_W-1:0] cmd_addr,
   input  logic [DATA_W-1:0] src_do,
   input  logic [LEN_W-1:0]  cmd_len,
   input  init_state_t       state,
   output logic [DATA_W-1:0] adio_in,
   output cbe_t              m_cbe,
   output logic              complete
);

   logic [LEN_W-1:0]  xfer_cnt;
   logic [DATA_W-3:0] word_addr;
   logic              m_dataq;
   logic              assert_complete;
   logic              hold_complete;

   always_ff @(posedge CLK or posedge reset) begin
      if (reset) begin
         xfer_cnt <= '0;
         m_dataq  <= 1'b0;
      end else begin
         m_dataq <= m_data;
         if (start) begin
            xfer_cnt <= cmd_len;
         end else if (m_data_vld) begin
            xfer_cnt <= xfer_cnt - 1'b1;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (start) begin
         word_addr <= cmd_addr[DATA_W-1:2];
      end else if (m_data_vld) begin
         word_addr <= word_addr + 1'b1;
      end
   end

   always_comb begin
      if (!m_addr_n) begin
         adio_in = {word_addr, 2'b00};
      end else if ((state == WRITE) && m_data) begin
         adio_in = src_do;
      end else begin
         adio_in = '0;
      end
   end

   always_comb begin
      m_cbe = '0;
      if (!m_addr_n) begin
         m_cbe.cmd.grp = CMD_GROUP_MEM;
         m_cbe.cmd.dir = m_wrdn;
      end else begin
         m_cbe.be_n = BE_ALL;
      end
   end

   // Warn the core ahead of the last word
   assign assert_complete = ((xfer_cnt == LEN_W'(1)) && request) ||
                            ((xfer_cnt == LEN_W'(2)) && m_dataq) ||
                            ((xfer_cnt == LEN_W'(3)) && m_data_vld);

   always_ff @(posedge CLK or posedge reset) begin
      if (reset) begin
         hold_complete <= 1'b0;
      end else if (data_fell) begin
         hold_complete <= 1'b0;
      end else if (assert_complete) begin
         hold_complete <= 1'b1;
      end
   end

   assign complete = assert_complete || hold_complete;

   a_cnt_no_underflow: assert property (@(posedge CLK) disable iff (reset)
      m_data_vld |-> xfer_cnt != '0);

endmodule

//--- verilog/src_fifo.sv
// Write data source FIFO
`timescale 1ns/1ns

module src_fifo #(
   parameter int DATA_W  = 32,
   parameter int FIFO_AW = 4
) (
   input  logic              CLK,
   input  logic              reset,
   input  logic              wr_req,
   input  logic              pop_enable,
   input  logic              m_src_en,
   input  logic [DATA_W-1:0] wr_data,
   output logic              wr_ack,
   output logic [DATA_W-1:0] src_do
);

   localparam int DEPTH = 2 ** FIFO_AW;

   logic [DATA_W-1:0] mem [DEPTH];
   logic [FIFO_AW:0]  wr_ptr;
   logic [FIFO_AW:0]  rd_ptr;
   logic              full;
   logic              empty;
   logic              push;
   logic              pop;

   // Extra pointer bit tells full from empty
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                  (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

   // One word per request, held off while full
   assign push = wr_req && !wr_ack && !full;
   assign pop  = pop_enable && m_src_en && !empty;

   assign src_do = mem[rd_ptr[FIFO_AW-1:0]];

   always_ff @(posedge CLK or posedge reset) begin
      if (reset) begin
         wr_ack <= 1'b0;
      end else if (push) begin
         wr_ack <= 1'b1;
      end else if (!wr_req) begin
         wr_ack <= 1'b0;
      end
   end

   always_ff @(posedge CLK or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (push) begin
         mem[wr_ptr[FIFO_AW-1:0]] <= wr_data;
      end
   end

   // Core must not fetch source data beyond what the user loaded
   a_no_pop_empty: assert property (@(posedge CLK) disable iff (reset)
      pop_enable && m_src_en |-> !empty);

endmodule

//--- verilog/pci_init_top.sv
// PCI initiator top level
`timescale 1ns/1ns

module pci_init_top
   import pci_bus_pkg::*, pci_init_pkg::*;
#(
   parameter int DATA_W  = 32,
   parameter int FIFO_AW = 4
) (
   input  logic              CLK,
   input  logic              reset,
   // User command handshake
   input  logic              cmd_req,
   input  logic              cmd_write,
   input  logic [DATA_W-1:0] cmd_addr,
   input  logic [LEN_W-1:0]  cmd_len,
   output logic              cmd_ack,
   input  logic              clear_dead,
   output logic              busy,
   output logic              dead,
   // User write data handshake
   input  logic              wr_req,
   input  logic [DATA_W-1:0] wr_data,
   output logic              wr_ack,
   // User read data
   output logic [DATA_W-1:0] rd_data,
   output logic              rd_valid,
   // PCI core side
   input  logic              m_data,
   input  logic              m_data_vld,
   input  logic              m_addr_n,
   input  logic              m_src_en,
   input  logic [CSR_W-1:0]  csr,
   input  logic [DATA_W-1:0] adio_out,
   output logic [DATA_W-1:0] adio_in,
   output cbe_t              m_cbe,
   output logic              m_wrdn,
   output logic              request,
   output logic              complete
);

   logic              start;
   logic              data_fell;
   logic              pop_enable;
   logic [DATA_W-1:0] src_do;
   init_state_t       state;

   assign rd_data    = adio_out;
   assign pop_enable = (state == WRITE);

   init_sequencer init_sequencer_i (.*);

   burst_tracker #(.DATA_W(DATA_W)) burst_tracker_i (.*);

   src_fifo #(.DATA_W(DATA_W), .FIFO_AW(FIFO_AW)) src_fifo_i (.*);

endmodule

//--- sim/tb_checks.svh
// Testbench checks and error counters
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int errors = 0;
int timeouts = 0;

function automatic void report_mismatch(input string name,
                                        input logic [DATA_W-1:0] expected,
                                        input logic [DATA_W-1:0] actual);
   errors++;
   $display("FAILED at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
endfunction

function automatic void report_timeout(input string what);
   timeouts++;
   $display("Timeout at %0t ns while waiting for %s", $time, what);
endfunction

a_reset_quiet: assert property (@(posedge CLK)
   $fell(reset) |-> !request && !complete && !cmd_ack && !busy)
   else report_mismatch("request/complete/cmd_ack/busy", '0,
                        DATA_W'({$sampled(request), $sampled(complete),
                                 $sampled(cmd_ack), $sampled(busy)}));

a_ack_needs_req: assert property (@(posedge CLK) disable iff (reset)
   $rose(cmd_ack) |-> $past(cmd_req))
   else report_mismatch("cmd_ack", '0, DATA_W'(1));

a_ack_drops: assert property (@(posedge CLK) disable iff (reset)
   cmd_ack && !cmd_req |=> !cmd_ack)
   else report_mismatch("cmd_ack", '0, DATA_W'(1));

// One request cycle per accepted command
a_request_once: assert property (@(posedge CLK) disable iff (reset)
   request == $rose(cmd_ack))
   else report_mismatch("request", DATA_W'(!$sampled(request)), DATA_W'($sampled(request)));

a_addr_phase: assert property (@(posedge CLK) disable iff (reset)
   !m_addr_n |-> adio_in == {cmd_addr[DATA_W-1:2], 2'b00})
   else report_mismatch("adio_in", {$sampled(cmd_addr[DATA_W-1:2]), 2'b00},
                        $sampled(adio_in));

a_cmd_code: assert property (@(posedge CLK) disable iff (reset)
   !m_addr_n |-> m_cbe == (cmd_write ? 4'b0111 : 4'b0110) && m_wrdn == cmd_write)
   else report_mismatch("m_cbe/m_wrdn", DATA_W'({3'b011, $sampled(cmd_write),
                        $sampled(cmd_write)}), DATA_W'({$sampled(m_cbe), $sampled(m_wrdn)}));

a_byte_enables: assert property (@(posedge CLK) disable iff (reset)
   m_data && m_addr_n |-> m_cbe == 4'b0000)
   else report_mismatch("m_cbe", '0, DATA_W'($sampled(m_cbe)));

a_write_data: assert property (@(posedge CLK) disable iff (reset)
   m_data_vld && cmd_write |-> adio_in == exp_word)
   else report_mismatch("adio_in", $sampled(exp_word), $sampled(adio_in));

a_read_valid: assert property (@(posedge CLK) disable iff (reset)
   rd_valid == (m_data_vld && !cmd_write))
   else report_mismatch("rd_valid", DATA_W'($sampled(m_data_vld && !cmd_write)),
                        DATA_W'($sampled(rd_valid)));

a_read_data: assert property (@(posedge CLK) disable iff (reset)
   rd_valid |-> rd_data == adio_out)
   else report_mismatch("rd_data", $sampled(adio_out), $sampled(rd_data));

a_complete_last: assert property (@(posedge CLK) disable iff (reset)
   m_data_vld && last_word |-> complete)
   else report_mismatch("complete", DATA_W'(1), '0);

a_complete_ends: assert property (@(posedge CLK) disable iff (reset)
   $fell(m_data) |=> !complete)
   else report_mismatch("complete", '0, DATA_W'(1));

a_dead_on_fatal: assert property (@(posedge CLK) disable iff (reset)
   $fell(m_data) |=> dead == $past(fatal_sent))
   else report_mismatch("dead", DATA_W'($sampled(fatal_sent)), DATA_W'($sampled(dead)));

// Dead holds until cleared and takes no command
a_dead_no_ack: assert property (@(posedge CLK) disable iff (reset)
   dead && !clear_dead |=> dead && !cmd_ack)
   else report_mismatch("dead/cmd_ack", DATA_W'(2'b10),
                        DATA_W'({$sampled(dead), $sampled(cmd_ack)}));

a_clear_dead: assert property (@(posedge CLK) disable iff (reset)
   clear_dead && dead |=> !dead && !busy)
   else report_mismatch("dead/busy", '0, DATA_W'({$sampled(dead), $sampled(busy)}));

`endif

//--- sim/tb_pci_init.sv
// PCI initiator testbench
`timescale 1ns/1ns

module tb_pci_init
   import pci_bus_pkg::*, pci_init_pkg::*;
();

   localparam int DATA_W  = 32;
   localparam int TIMEOUT = 200;

   logic              CLK;
   logic              reset;
   logic              cmd_req, cmd_write, clear_dead, wr_req;
   logic              m_data, m_data_vld, m_addr_n, m_src_en;
   logic [DATA_W-1:0] cmd_addr, wr_data, adio_out, rd_data, adio_in;
   logic [LEN_W-1:0]  cmd_len;
   logic [CSR_W-1:0]  csr;
   logic              cmd_ack, wr_ack, busy, dead, rd_valid, m_wrdn, request, complete;
   cbe_t              m_cbe;

   integer            seed;
   logic [DATA_W-1:0] exp_word;
   logic              last_word;
   logic              fatal_sent;
   logic [DATA_W-1:0] wr_queue [$];

   `include "tb_checks.svh"

   pci_init_top #(.DATA_W(DATA_W), .FIFO_AW(4)) pci_init_top_i (.*);

   initial begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

   task automatic tick();
      @(posedge CLK);
      #1;
   endtask

   task automatic load_word(input logic [DATA_W-1:0] data);
      int n;
      n = 0;
      wr_data = data;
      wr_req = 1'b1;
      while (!wr_ack && n < TIMEOUT) begin
         tick();
         n++;
      end
      if (!wr_ack) report_timeout("wr_ack high");
      wr_queue.push_back(data);
      wr_req = 1'b0;
      n = 0;
      while (wr_ack && n < TIMEOUT) begin
         tick();
         n++;
      end
      if (wr_ack) report_timeout("wr_ack low");
   endtask

   task automatic issue_command(input logic [DATA_W-1:0] addr, input int len,
                                input logic write);
      int n;
      n = 0;
      cmd_addr = addr;
      cmd_len = LEN_W'(len);
      cmd_write = write;
      cmd_req = 1'b1;
      while (!cmd_ack && n < TIMEOUT) begin
         tick();
         n++;
      end
      if (!cmd_ack) report_timeout("cmd_ack high");
      cmd_req = 1'b0;
      n = 0;
      while (cmd_ack && n < TIMEOUT) begin
         tick();
         n++;
      end
      if (cmd_ack) report_timeout("cmd_ack low");
   endtask

   // Core model with one address phase and len data words
   task automatic core_burst(input int len, input logic write, input logic fatal);
      int n;
      n = 0;
      while (!request && n < TIMEOUT) begin
         tick();
         n++;
      end
      if (!request) begin
         report_timeout("request");
         return;
      end
      repeat (1 + {$random(seed)} % 4) tick();
      m_addr_n = 1'b0;
      fatal_sent = 1'b0;
      tick();
      m_addr_n = 1'b1;
      m_data = 1'b1;
      tick();
      for (int i = 0; i < len; i++) begin
         repeat ({$random(seed)} % 3) tick();
         m_data_vld = 1'b1;
         m_src_en = write;
         last_word = (i == len - 1);
         if (write) begin
            exp_word = wr_queue.pop_front();
         end else begin
            adio_out = $random(seed);
         end
         if (fatal && i == 0) begin
            csr[CSR_FATAL_HI] = 1'b1;
            fatal_sent = 1'b1;
         end
         tick();
         m_data_vld = 1'b0;
         m_src_en = 1'b0;
         last_word = 1'b0;
         csr = '0;
      end
      m_data = 1'b0;
      repeat (3) tick();
   endtask

   task automatic do_transfer(input logic [DATA_W-1:0] addr, input int len,
                              input logic write, input logic fatal);
      if (write) begin
         for (int i = 0; i < len; i++) load_word($random(seed));
      end
      fork
         issue_command(addr, len, write);
         core_burst(len, write, fatal);
      join
   endtask

   initial begin
      seed = 32'h3fba_a8ae;
      reset = 1'b1;
      {cmd_req, cmd_write, clear_dead, wr_req, m_data, m_data_vld, m_src_en} = '0;
      m_addr_n = 1'b1;
      {cmd_addr, wr_data, adio_out, exp_word} = '0;
      cmd_len = '0;
      csr = '0;
      last_word = 1'b0;
      fatal_sent = 1'b0;
      repeat (10) @(posedge CLK);
      #1;
      reset = 1'b0;
      tick();

      do_transfer(32'h1000_0013, 4, 1'b0, 1'b0);
      do_transfer(32'h2000_0040, 3, 1'b1, 1'b0);
      do_transfer(32'h3000_0108, 1, 1'b0, 1'b0);
      do_transfer(32'h4000_0ffe, 2, 1'b1, 1'b0);
      do_transfer(32'h5000_0200, 5, 1'b1, 1'b1);

      // Dead initiator ignores the next command
      cmd_addr = 32'h6000_0000;
      cmd_req = 1'b1;
      repeat (8) tick();
      cmd_req = 1'b0;
      tick();
      clear_dead = 1'b1;
      tick();
      clear_dead = 1'b0;
      tick();

      do_transfer(32'h7000_0024, 2, 1'b0, 1'b0);
      repeat (4) tick();

      $display("Closing report: %0d check errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- files.f
+incdir+sim
verilog/pci_bus_pkg.sv
verilog/pci_init_pkg.sv
verilog/init_sequencer.sv
verilog/burst_tracker.sv
verilog/src_fifo.sv
verilog/pci_init_top.sv
sim/tb_pci_init.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_pci_init
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
